//--- ahb_pkg.sv
package ahb_pkg;

  //////////////////////////////////////////////////
  // bus widths
  //////////////////////////////////////////////////
  localparam int addr_w   = 32;         // haddr width.
  localparam int data_w   = 32;         // hwdata / hrdata width.
  localparam int n_lanes  = data_w / 8; // byte lanes per beat.
  localparam int region_w = 20;         // slave region field.
  localparam int idx_w    = 10;         // word index field.
  localparam int off_w    = 2;          // byte offset in word.

  //////////////////////////////////////////////////
  // transfer encodings
  //////////////////////////////////////////////////
  typedef enum logic [1:0] {
    IDLE   = 2'b00,                     // no transfer.
    BUSY   = 2'b01,                     // master stall, no transfer.
    NONSEQ = 2'b10,                     // single or first beat.
    SEQ    = 2'b11                      // handled like nonseq.
  } htrans_e;

  typedef enum logic [2:0] {
    BYTE = 3'b000,
    HALF = 3'b001,
    WORD = 3'b010
  } hsize_e;

  // one address word, two decodes.
  typedef union packed {
    logic [addr_w-1:0] haddr;           // flat view.
    struct packed {
      logic [region_w-1:0] region;      // decoder view.
      logic [idx_w-1:0]    word_idx;    // sram row.
      logic [off_w-1:0]    byte_off;    // lane select.
    } fields;
  } ahb_addr_u;

  typedef struct packed {
    ahb_addr_u addr;
    htrans_e   htrans;
    logic      hwrite;                  // 1 = write.
    hsize_e    hsize;
  } ahb_req_t;                          // address phase, 38 bits.

  typedef struct packed {
    logic [data_w-1:0] hrdata;
    logic              hready;          // hreadyout on a slave.
    logic              hresp;           // 1 = error.
  } ahb_rsp_t;                          // data phase, 34 bits.

endpackage

//--- mem_map_pkg.sv
package mem_map_pkg;

  //////////////////////////////////////////////////
  // slave map
  //////////////////////////////////////////////////
  localparam int n_slaves = 2;          // sram_0 and sram_1.

  // region field values, one 4 KB window each.
  localparam logic [ahb_pkg::region_w-1:0] sram0_region = 20'h00000;
  localparam logic [ahb_pkg::region_w-1:0] sram1_region = 20'h00001;

  //////////////////////////////////////////////////
  // memory geometry
  //////////////////////////////////////////////////
  localparam int mem_depth = 256;                 // words per sram.
  localparam int mem_aw    = $clog2(mem_depth);   // low word_idx bits used.

  // upper word_idx bits alias onto the same rows.

  //////////////////////////////////////////////////
  // slave timing
  //////////////////////////////////////////////////
  localparam int sram1_wait = 1;        // wait states on slave 1.

endpackage

//--- ahb_decoder.sv
`timescale 1ns/1ps

module ahb_decoder (
  input  ahb_pkg::ahb_req_t                req,
  output logic [mem_map_pkg::n_slaves-1:0] hsel,
  output logic                             hsel_none
);

  import ahb_pkg::*;
  import mem_map_pkg::*;

  //////////////////////////////////////////////////
  // region table, index = slave number
  //////////////////////////////////////////////////
  localparam logic [region_w-1:0] region_tab [n_slaves] = '{
    sram0_region,                       // slave 0.
    sram1_region                        // slave 1.
  };

  logic                active;          // nonseq or seq.
  logic [n_slaves-1:0] hit;             // raw region match.

  assign active = (req.htrans == NONSEQ) || (req.htrans == SEQ);

  // compare every window, no priority needed.
  always_comb begin
    for (int s = 0; s < n_slaves; s++) begin
      hit[s] = (req.addr.fields.region == region_tab[s]);
    end
  end

  //////////////////////////////////////////////////
  // select outputs
  //////////////////////////////////////////////////
  // idle and busy select nothing.
  always_comb begin
    hsel      = '0;
    hsel_none = 1'b0;
    if (active) begin
      hsel      = hit;                  // one-hot, windows disjoint.
      hsel_none = (hit == '0);          // unmapped goes to error slave.
    end
  end

  // note that hsel is address-phase only. the response mux
  // latches it on hready to find the data-phase owner.

endmodule

//--- ahb_sram.sv
`timescale 1ns/1ps

module ahb_sram #(
  parameter int unsigned wait_states = 0  // 0 to 3.
) (
  input  logic                        clk,
  input  logic                        rst,
  input  logic                        hsel,
  input  ahb_pkg::ahb_req_t           req,
  input  logic [ahb_pkg::data_w-1:0]  hwdata,
  input  logic                        hready,
  output ahb_pkg::ahb_rsp_t           rsp
);

  import ahb_pkg::*;
  import mem_map_pkg::*;

  logic [data_w-1:0]  mem [mem_depth];  // storage, no reset.

  //////////////////////////////////////////////////
  // address phase capture
  //////////////////////////////////////////////////
  logic               accept;           // selected and bus ready.
  logic [n_lanes-1:0] strb_next;        // lanes of the new transfer.

  logic               dp_valid;         // data phase pending here.
  logic [1:0]         wait_cnt;         // remaining wait cycles.
  logic               dp_write;
  logic [mem_aw-1:0]  dp_idx;           // row of the data phase.
  logic [n_lanes-1:0] dp_strb;
  logic               dp_done;          // data phase ends this edge.

  assign accept = hsel && hready;

  // lane strobes from size and offset.
  always_comb begin
    case (req.hsize)
      BYTE:    strb_next = n_lanes'(1) << req.addr.fields.byte_off;
      HALF:    strb_next = req.addr.fields.byte_off[1] ? 4'b1100 : 4'b0011;
      default: strb_next = '1;          // word.
    endcase
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      dp_write <= req.hwrite;
      dp_idx   <= req.addr.fields.word_idx[mem_aw-1:0]; // upper bits alias.
      dp_strb  <= strb_next;
    end
  end

  //////////////////////////////////////////////////
  // data phase control
  //////////////////////////////////////////////////
  assign dp_done = dp_valid && (wait_cnt == '0);

  always_ff @(posedge clk) begin
    if (rst) begin
      dp_valid <= 1'b0;
      wait_cnt <= '0;
    end else begin
      if (accept) begin
        dp_valid <= 1'b1;               // back to back allowed.
        wait_cnt <= 2'(wait_states);
      end else if (dp_done) begin
        dp_valid <= 1'b0;
      end else if (dp_valid) begin
        wait_cnt <= wait_cnt - 2'd1;    // one wait cycle gone.
      end
    end
  end

  //////////////////////////////////////////////////
  // memory update and response
  //////////////////////////////////////////////////
  // write lands on the edge closing the data phase.
  always_ff @(posedge clk) begin
    if (dp_done && dp_write) begin
      for (int b = 0; b < n_lanes; b++) begin
        if (dp_strb[b])
          mem[dp_idx][8*b +: 8] <= hwdata[8*b +: 8];
      end
    end
  end

  // async row read, so a read right after a write sees it.
  assign rsp.hrdata = mem[dp_idx];
  assign rsp.hready = !dp_valid || (wait_cnt == '0); // low during waits.
  assign rsp.hresp  = 1'b0;             // always okay.

endmodule

//--- ahb_resp_mux.sv
`timescale 1ns/1ps

module ahb_resp_mux (
  input  logic                             clk,
  input  logic                             rst,
  input  ahb_pkg::ahb_req_t                req,
  input  logic [mem_map_pkg::n_slaves-1:0] hsel,
  input  logic                             hsel_none,
  input  ahb_pkg::ahb_rsp_t                slave_rsp [mem_map_pkg::n_slaves],
  output ahb_pkg::ahb_rsp_t                rsp
);

  import ahb_pkg::*;
  import mem_map_pkg::*;

  typedef enum logic {
    ERR_FIRST = 1'b0,                   // hready low, hresp high.
    ERR_LAST  = 1'b1                    // hready high, hresp high.
  } err_e;

  logic                active;          // address phase carries a transfer.
  logic [n_slaves-1:0] owner;           // one-hot data phase owner.
  logic                owner_none;      // default slave owns it.
  err_e                err_st;

  assign active = (req.htrans == NONSEQ) || (req.htrans == SEQ);

  //////////////////////////////////////////////////
  // data phase owner and error machine
  //////////////////////////////////////////////////
  always_ff @(posedge clk) begin
    if (rst) begin
      owner      <= '0;                 // nothing pending.
      owner_none <= 1'b0;
      err_st     <= ERR_FIRST;
    end else begin
      if (owner_none && (err_st == ERR_FIRST))
        err_st <= ERR_LAST;             // second error cycle next.
      if (rsp.hready) begin
        owner      <= active ? hsel : '0;
        owner_none <= active && hsel_none;
        err_st     <= ERR_FIRST;        // rearm for next error.
      end
    end
  end

  //////////////////////////////////////////////////
  // response select
  //////////////////////////////////////////////////
  always_comb begin
    rsp = '{hrdata: '0, hready: 1'b1, hresp: 1'b0}; // idle, okay.
    if (owner_none) begin
      rsp.hready = (err_st == ERR_LAST);
      rsp.hresp  = 1'b1;
    end else begin
      for (int s = 0; s < n_slaves; s++) begin
        if (owner[s])
          rsp = slave_rsp[s];           // forward owner's data phase.
      end
    end
  end

endmodule

//--- ahb_subsystem_top.sv
`timescale 1ns/1ps

module ahb_subsystem_top (
  input  logic                       clk,
  input  logic                       rst,
  input  ahb_pkg::ahb_req_t          m_req,
  input  logic [ahb_pkg::data_w-1:0] m_hwdata,
  output ahb_pkg::ahb_rsp_t          m_rsp
);

  import ahb_pkg::*;
  import mem_map_pkg::*;

  logic [n_slaves-1:0] hsel;            // address phase selects.
  logic                hsel_none;       // unmapped transfer.
  ahb_rsp_t            slave_rsp [n_slaves];

  //////////////////////////////////////////////////
  // decode, slaves, response
  //////////////////////////////////////////////////
  ahb_decoder u_dec (
    .req       (m_req),
    .hsel      (hsel),
    .hsel_none (hsel_none)
  );

  ahb_sram #(.wait_states(0)) sram_0 (  // zero wait.
    .clk    (clk),
    .rst    (rst),
    .hsel   (hsel[0]),
    .req    (m_req),
    .hwdata (m_hwdata),
    .hready (m_rsp.hready),             // bus hready fed back.
    .rsp    (slave_rsp[0])
  );

  ahb_sram #(.wait_states(sram1_wait)) sram_1 (
    .clk    (clk),
    .rst    (rst),
    .hsel   (hsel[1]),
    .req    (m_req),
    .hwdata (m_hwdata),
    .hready (m_rsp.hready),
    .rsp    (slave_rsp[1])
  );

  ahb_resp_mux u_mux (
    .clk       (clk),
    .rst       (rst),
    .req       (m_req),
    .hsel      (hsel),
    .hsel_none (hsel_none),
    .slave_rsp (slave_rsp),
    .rsp       (m_rsp)                  // also the bus hready.
  );

endmodule

//--- ahb_subsystem_chk.sv
`timescale 1ns/1ps

module ahb_subsystem_chk (
  input logic              clk,
  input logic              rst,
  input ahb_pkg::ahb_rsp_t m_rsp
);

  logic [2:0] low_cnt;                  // hready low cycles so far.
  logic       err_first_bad = 1'b0;
  logic       err_last_bad  = 1'b0;
  logic       rst_bad       = 1'b0;
  logic       len_bad       = 1'b0;
  logic       fail_seen;                // any assertion has fired.

  assign fail_seen = err_first_bad | err_last_bad | rst_bad | len_bad;

  always_ff @(posedge clk) begin
    if (rst || m_rsp.hready)
      low_cnt <= '0;
    else
      low_cnt <= low_cnt + 3'd1;
  end

  //////////////////////////////////////////////////
  // error response shape
  //////////////////////////////////////////////////
  a_err_first: assert property (@(posedge clk) disable iff (rst)
    (m_rsp.hresp && !m_rsp.hready) |=> (m_rsp.hresp && m_rsp.hready))
    else begin
      err_first_bad = 1'b1;
      $error("first error cycle not followed by the closing error cycle");
    end

  a_err_last: assert property (@(posedge clk) disable iff (rst)
    (m_rsp.hresp && m_rsp.hready) |-> $past(m_rsp.hresp && !m_rsp.hready))
    else begin
      err_last_bad = 1'b1;
      $error("hresp high without a preceding wait cycle");
    end

  // idle okay once reset has been seen.
  a_rst_idle: assert property (@(posedge clk)
    rst |=> (m_rsp.hready && !m_rsp.hresp))
    else begin
      rst_bad = 1'b1;
      $error("response not ready and okay after reset");
    end

  //////////////////////////////////////////////////
  // data phase length
  //////////////////////////////////////////////////
  a_len: assert property (@(posedge clk) disable iff (rst)
    !m_rsp.hready |-> (low_cnt < 3'd3))   // at most 4 cycles per phase.
    else begin
      len_bad = 1'b1;
      $error("data phase longer than four cycles");
    end

endmodule

//--- tb_ahb_subsystem.sv
`timescale 1ns/1ps

module tb_ahb_subsystem;

  import ahb_pkg::*;
  import mem_map_pkg::*;

  typedef struct packed {
    logic [addr_w-1:0] addr;
    logic              write;
    hsize_e            size;
    logic [data_w-1:0] wdata;
  } op_t;                               // one queued transfer.

  localparam int max_wait = 8;          // hready low limit per phase.
  localparam logic [region_w-1:0] bad_region = 20'h00040; // unmapped window.

  logic              clk = 1'b0;
  logic              rst;
  ahb_req_t          m_req;
  logic [data_w-1:0] m_hwdata;
  ahb_rsp_t          m_rsp;

  logic [31:0] lfsr = 32'd7;            // seed.
  logic [7:0]  model [n_slaves][mem_depth*4]; // byte image per sram.
  op_t         ops [$];                 // pending transfers.

  always #10 clk = ~clk;                // 20 ns period.

  ahb_subsystem_top uut (
    .clk      (clk),
    .rst      (rst),
    .m_req    (m_req),
    .m_hwdata (m_hwdata),
    .m_rsp    (m_rsp)
  );

  bind ahb_subsystem_top ahb_subsystem_chk u_chk (
    .clk   (clk),
    .rst   (rst),
    .m_rsp (m_rsp)
  );

  task automatic fail_run();
    $display("TEST FAILED");
    $fatal(1);
  endtask

  // galois lfsr stepped once per bit.
  function automatic logic [31:0] rand_bits(int n);
    logic [31:0] r;
    r = '0;
    for (int i = 0; i < n; i++) begin
      r    = {r[30:0], lfsr[0]};
      lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h80200003) : (lfsr >> 1);
    end
    return r;
  endfunction

  function automatic int slave_of(logic [addr_w-1:0] a);
    if (a[31:12] == sram0_region)
      return 0;
    if (a[31:12] == sram1_region)
      return 1;
    return -1;                          // no slave.
  endfunction

  // lanes covered by an aligned transfer of 2**size bytes.
  function automatic logic [3:0] lane_mask(hsize_e size, logic [1:0] off);
    int         nbytes;
    int         base;
    logic [3:0] m;
    nbytes = 1 << int'(size);
    base   = int'(off) & ~(nbytes - 1);
    for (int b = 0; b < 4; b++)
      m[b] = (b >= base) && (b < base + nbytes);
    return m;
  endfunction

  task automatic push_op(logic [region_w-1:0] region, int idx, int off, logic write,
                         hsize_e size);
    op_t op;
    op.addr  = {region, 10'(idx), 2'(off)};
    op.write = write;
    op.size  = size;
    op.wdata = write ? rand_bits(32) : '0;
    ops.push_back(op);
  endtask

  task automatic drive_addr(int i);
    m_req = '0;                         // idle.
    if (i < ops.size()) begin
      m_req.addr.haddr = ops[i].addr;
      m_req.htrans     = NONSEQ;
      m_req.hwrite     = ops[i].write;
      m_req.hsize      = ops[i].size;
    end
  endtask

  // checks on the last data phase cycle at negedge.
  task automatic close_phase(op_t op, int waits);
    int          s;
    int          row;
    int          exp_wait;
    logic [3:0]  lanes;
    logic [31:0] exp;
    s        = slave_of(op.addr);
    row      = int'(op.addr[11:2]) % mem_depth; // high rows alias.
    lanes    = lane_mask(op.size, op.addr[1:0]);
    exp_wait = (s < 0) ? 1 : ((s == 1) ? sram1_wait : 0);
    assert (waits == exp_wait) else begin
      $display("Fail hready wait cycles exp %h got %h", exp_wait, waits);
      fail_run();
    end
    assert (m_rsp.hresp == (s < 0)) else begin
      $display("Fail hresp exp %h got %h", s < 0, m_rsp.hresp);
      fail_run();
    end
    if (s >= 0 && op.write) begin
      for (int b = 0; b < 4; b++)
        if (lanes[b])
          model[s][row*4+b] = op.wdata[8*b +: 8];
    end else if (s >= 0) begin
      exp = {model[s][row*4+3], model[s][row*4+2], model[s][row*4+1], model[s][row*4]};
      assert (m_rsp.hrdata == exp) else begin
        $display("Fail hrdata exp %h got %h", exp, m_rsp.hrdata);
        fail_run();
      end
    end
  endtask

  //////////////////////////////////////////////////
  // pipelined master
  //////////////////////////////////////////////////
  task automatic run_ops();
    int   head;
    int   dp_i;
    int   waits;
    logic dp_v;
    logic adv;
    head  = 0;
    dp_i  = 0;
    waits = 0;
    dp_v  = 1'b0;
    adv   = 1'b1;
    while ((head < ops.size()) || dp_v) begin
      @(posedge clk);
      #1;
      if (adv) begin
        drive_addr(head);               // next address phase.
        if (dp_v && ops[dp_i].write)
          m_hwdata = ops[dp_i].wdata;   // data of the accepted one.
      end
      @(negedge clk);
      adv = m_rsp.hready;
      if (adv) begin
        if (dp_v)
          close_phase(ops[dp_i], waits);
        dp_v  = (head < ops.size());
        dp_i  = head;
        waits = 0;
        if (dp_v)
          head++;
      end else begin
        waits++;
        if (waits > max_wait) begin
          $display("timeout, hready stayed low for more than %0d cycles", max_wait);
          fail_run();
        end
      end
    end
    ops.delete();
  endtask

  always @(negedge clk) begin
    if (uut.u_chk.fail_seen) begin
      $display("a protocol assertion on the top level ports failed");
      fail_run();
    end
  end

  //////////////////////////////////////////////////
  // stimulus
  //////////////////////////////////////////////////
  initial begin
    int                  row;
    logic [region_w-1:0] reg_sel;
    rst      = 1'b1;
    m_req    = '0;
    m_hwdata = '0;
    repeat (3) @(posedge clk);
    #1;
    rst = 1'b0;
    @(negedge clk);
    assert (m_rsp.hready && !m_rsp.hresp) else begin
      $display("Fail m_rsp hready/hresp exp 1/0 got %h/%h", m_rsp.hready, m_rsp.hresp);
      fail_run();
    end
    for (int i = 0; i < mem_depth; i++) begin // fill with slaves alternating.
      push_op(sram0_region, i, 0, 1'b1, WORD);
      push_op(sram1_region, i, 0, 1'b1, WORD);
    end
    run_ops();
    for (int i = 0; i < 72; i++) begin  // random writes then reads.
      reg_sel = rand_bits(1) ? sram1_region : sram0_region;
      row     = int'(rand_bits(10));
      push_op(reg_sel, row, 0, (i < 24), WORD);
    end
    run_ops();
    for (int s = 0; s < n_slaves; s++) begin // lane merging.
      reg_sel = (s == 0) ? sram0_region : sram1_region;
      row     = int'(rand_bits(8));
      for (int off = 0; off < 4; off++) begin
        push_op(reg_sel, row, off, 1'b1, BYTE);
        push_op(reg_sel, row, 0, 1'b0, WORD);
      end
      for (int off = 0; off < 4; off += 2) begin
        push_op(reg_sel, row, off, 1'b1, HALF);
        push_op(reg_sel, row, 0, 1'b0, WORD);
      end
    end
    push_op(bad_region, 5, 0, 1'b1, WORD); // unmapped write must not land.
    push_op(sram0_region, 5, 0, 1'b0, WORD);
    push_op(bad_region, 5, 0, 1'b0, WORD);
    push_op(sram1_region, 5, 0, 1'b0, WORD);
    run_ops();
    for (int i = 0; i < 16; i++) begin  // write then read same row.
      reg_sel = i[0] ? sram1_region : sram0_region;
      row     = int'(rand_bits(10));
      push_op(reg_sel, row, 0, 1'b1, WORD);
      push_op(reg_sel, row, 0, 1'b0, WORD);
    end
    for (int i = 0; i < mem_depth; i++) begin // full readback.
      push_op(sram0_region, i, 0, 1'b0, WORD);
      push_op(sram1_region, i, 0, 1'b0, WORD);
    end
    run_ops();
    $display("TEST PASSED");
    $finish;
  end

endmodule

//--- filelist.f
ahb_pkg.sv
mem_map_pkg.sv
ahb_decoder.sv
ahb_sram.sv
ahb_resp_mux.sv
ahb_subsystem_top.sv
ahb_subsystem_chk.sv
tb_ahb_subsystem.sv

//--- run.sh
#!/bin/sh
# build and run the AHB subsystem testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
  --top-module tb_ahb_subsystem \
  -f filelist.f \
  -o tb_sim

./obj_dir/tb_sim +verilator+error+limit+100
